// ==== verif/kmeans_patterns.txt ====
# t <name> <dim> <clusters> | s <cluster> <min_dist> <one feature per dimension>
# e <counts, then sums cluster-major, then sse>; all numbers hex
t count_sum_sse 4 2
s 0 5 1 2 3 4
s 0 7 10 20 30 40
s 1 3 100 200 300 400
s 0 1 1 1 1 1
e 3 1 12 23 34 45 100 200 300 400 10
t clear_second_iter 4 2
s 1 2 5 6 7 8
s 1 20 ffffffff 1 0 a
e 0 2 0 0 0 0 100000004 7 7 12 22
t wide_dims 6 3
s 2 1 1 2 3 4 5 6
s 0 2 10 10 10 10 10 10
s 2 4 1 1 1 1 1 1
s 1 8 a b c d e f
e 1 1 2 10 10 10 10 10 10 a b c d e f 2 3 4 5 6 7 f

// ==== files.f ====
source/kmeans_cfg_pkg.sv
source/kmeans_agg_pkg.sv
source/accu_ifs.sv
source/sync_fifo.sv
source/accu_ram.sv
source/sample_pairing.sv
source/centroid_accumulator.sv
source/result_sequencer.sv
source/kmeans_accumulation.sv
verif/kmeans_accumulation_assertions.sv
verif/tb_kmeans_accumulation.sv

// ==== verif/tb_kmeans_accumulation.sv ====
`timescale 1ns/1ns

module tb_kmeans_accumulation;
	import kmeans_cfg_pkg::*;
	import kmeans_agg_pkg::*;

	// random test uses every cluster and dimension
	localparam int RAND_SAMPLES = 48;
	localparam int RAND_CLUSTERS = 2**MAX_CLUSTER_BITS;
	localparam int RAND_DIM = 2**MAX_DIM_BITS;

	logic clk;
	logic rst_n_reg;
	logic feature_valid_i;
	feature_t feature_i;
	logic dist_valid_i;
	acc_word_t min_dist_i;
	cluster_t cluster_i;
	logic terminate_i;
	dim_t data_dim_i;
	cluster_t num_cluster_i;
	logic agg_ready_i;
	logic accu_finish_o;
	logic agg_valid_o;
	acc_word_t agg_data_o;

	// stimulus and expected words of the current test
	cluster_t smp_cluster [$];
	acc_word_t smp_dist [$];
	feature_t feat [$];
	acc_word_t exp_words [$];

	logic [31:0] rng;
	string cur_name;
	int cycle_cnt = 0;
	// 0 while no test is running
	int deadline = 0;
	int test_cnt = 0;
	int failed_tests = 0;
	int check_cnt = 0;
	int error_cnt = 0;

	kmeans_accumulation i_dut (
		.clk(clk),
		.rst_n_reg(rst_n_reg),
		.feature_valid_i(feature_valid_i),
		.feature_i(feature_i),
		.dist_valid_i(dist_valid_i),
		.min_dist_i(min_dist_i),
		.cluster_i(cluster_i),
		.terminate_i(terminate_i),
		.data_dim_i(data_dim_i),
		.num_cluster_i(num_cluster_i),
		.agg_ready_i(agg_ready_i),
		.accu_finish_o(accu_finish_o),
		.agg_valid_o(agg_valid_o),
		.agg_data_o(agg_data_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// deadline is re-armed at the start of each test
	initial begin
		while (deadline == 0 || cycle_cnt < deadline) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: test %s still running after %0d cycles", cur_name, cycle_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// drive and sample point, 2 ns past the edge
	task automatic step;
		@(posedge clk);
		#2;
	endtask

	task automatic check_count(input string name, input int clus, input acc_word_t exp_v,
		input acc_word_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			error_cnt++;
			$display("error %s: count of cluster %0d expected %0h actual %0h",
				name, clus, exp_v, act_v);
		end
	endtask

	task automatic check_sum(input string name, input int clus, input int dim,
		input acc_word_t exp_v, input acc_word_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			error_cnt++;
			$display("error %s: sum of cluster %0d dim %0d expected %0h actual %0h",
				name, clus, dim, exp_v, act_v);
		end
	endtask

	task automatic check_sse(input string name, input acc_word_t exp_v, input acc_word_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			error_cnt++;
			$display("error %s: sse expected %0h actual %0h", name, exp_v, act_v);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one iteration: samples, terminate, burst, compare
	//////////////////////////////////////////////////////////////////////

	task automatic run_test(input string name, input int dim, input int nclus);
		acc_word_t got [$];
		int nwords;
		int errs_before;
		int extra;
		nwords = nclus * (dim + 1) + 1;
		errs_before = error_cnt;
		extra = 0;
		cur_name = name;
		deadline = cycle_cnt + (smp_cluster.size() * RAND_DIM + nwords) * 4 + 200;
		data_dim_i = dim_t'(dim);
		num_cluster_i = cluster_t'(nclus);
		step();
		// one feature per cycle, cluster record with the first
		for (int s = 0; s < smp_cluster.size(); s++) begin
			for (int d = 0; d < dim; d++) begin
				feature_valid_i = 1'b1;
				feature_i = feat[s * dim + d];
				dist_valid_i = (d == 0);
				cluster_i = smp_cluster[s];
				min_dist_i = smp_dist[s];
				step();
			end
		end
		feature_valid_i = 1'b0;
		dist_valid_i = 1'b0;
		terminate_i = 1'b1;
		step();
		terminate_i = 1'b0;
		while (!accu_finish_o) begin
			step();
		end
		// aggregator holds off a few cycles
		repeat (5) begin
			step();
			if (!accu_finish_o || agg_valid_o) begin
				error_cnt++;
				$display("%s: finish flag dropped or a word came out before agg_ready_i", name);
			end
		end
		agg_ready_i = 1'b1;
		while (got.size() < nwords) begin
			step();
			if (!accu_finish_o) begin
				agg_ready_i = 1'b0;
			end
			if (agg_valid_o) begin
				got.push_back(agg_data_o);
			end
		end
		repeat (10) begin
			step();
			if (agg_valid_o) begin
				extra++;
			end
		end
		if (extra != 0) begin
			error_cnt++;
			$display("%s: %0d words came out after the expected %0d", name, extra, nwords);
		end
		// counts, cluster-major sums, sse last
		for (int k = 0; k < nclus; k++) begin
			check_count(name, k, exp_words[k], got[k]);
		end
		for (int k = 0; k < nclus * dim; k++) begin
			check_sum(name, k / dim, k % dim, exp_words[nclus + k], got[nclus + k]);
		end
		check_sse(name, exp_words[nwords - 1], got[nwords - 1]);
		test_cnt++;
		if (error_cnt != errs_before) begin
			failed_tests++;
		end
		$display("test %s: %0d words, %0d errors", name, nwords, error_cnt - errs_before);
		smp_cluster.delete();
		smp_dist.delete();
		feat.delete();
		exp_words.delete();
		deadline = 0;
	endtask

	task automatic run_patterns;
		int fd;
		int rc;
		int dim;
		int nclus;
		int clus;
		string tag;
		string name;
		string rest;
		acc_word_t value;
		dim = 0;
		nclus = 0;
		fd = $fopen("verif/kmeans_patterns.txt", "r");
		if (fd == 0) begin
			error_cnt++;
			$display("cannot open the pattern file verif/kmeans_patterns.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag.substr(0, 0) == "#") begin
					rc = $fgets(rest, fd);
				end else if (tag == "t") begin
					rc = $fscanf(fd, "%s %h %h", name, dim, nclus);
				end else if (tag == "s") begin
					rc = $fscanf(fd, "%h %h", clus, value);
					smp_cluster.push_back(cluster_t'(clus));
					smp_dist.push_back(value);
					for (int d = 0; d < dim; d++) begin
						rc = $fscanf(fd, "%h", value);
						feat.push_back(feature_t'(value));
					end
				end else if (tag == "e") begin
					for (int i = 0; i < nclus * (dim + 1) + 1; i++) begin
						rc = $fscanf(fd, "%h", value);
						exp_words.push_back(value);
					end
					run_test(name, dim, nclus);
				end else begin
					error_cnt++;
					$display("unknown tag %s in the pattern file", tag);
				end
			end
			$fclose(fd);
		end
	endtask

	// random samples plus reference counts, sums and sse
	task automatic build_random;
		acc_word_t sums [RAND_CLUSTERS][RAND_DIM];
		acc_word_t counts [RAND_CLUSTERS];
		acc_word_t sse;
		int c;
		sse = '0;
		for (int i = 0; i < RAND_CLUSTERS; i++) begin
			counts[i] = '0;
			for (int d = 0; d < RAND_DIM; d++) begin
				sums[i][d] = '0;
			end
		end
		for (int s = 0; s < RAND_SAMPLES; s++) begin
			rng = xorshift(rng);
			c = int'(rng[MAX_CLUSTER_BITS-1:0]);
			rng = xorshift(rng);
			smp_cluster.push_back(cluster_t'(c));
			smp_dist.push_back(acc_word_t'(rng));
			counts[c] = counts[c] + 1;
			sse = sse + acc_word_t'(rng);
			for (int d = 0; d < RAND_DIM; d++) begin
				rng = xorshift(rng);
				feat.push_back(rng);
				sums[c][d] = sums[c][d] + acc_word_t'(rng);
			end
		end
		for (int i = 0; i < RAND_CLUSTERS; i++) begin
			exp_words.push_back(counts[i]);
		end
		for (int i = 0; i < RAND_CLUSTERS; i++) begin
			for (int d = 0; d < RAND_DIM; d++) begin
				exp_words.push_back(sums[i][d]);
			end
		end
		exp_words.push_back(sse);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_n_reg = 1'b0;
		feature_valid_i = 1'b0;
		feature_i = '0;
		dist_valid_i = 1'b0;
		min_dist_i = '0;
		cluster_i = '0;
		terminate_i = 1'b0;
		data_dim_i = dim_t'(MIN_DIM);
		num_cluster_i = cluster_t'(1);
		agg_ready_i = 1'b0;
		rng = 32'h9306_3ff0;
		repeat (2) @(posedge clk);
		#2;
		rst_n_reg = 1'b1;
		run_patterns();
		build_random();
		run_test("random_wide", RAND_DIM, RAND_CLUSTERS);
		error_cnt = error_cnt + i_dut.i_assertions.fail_cnt;
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			test_cnt, failed_tests, check_cnt, error_cnt, i_dut.i_assertions.fail_cnt);
		if (error_cnt == 0 && failed_tests == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== verif/kmeans_accumulation_assertions.sv ====
`timescale 1ns/1ns

module kmeans_accumulation_assertions (
	input logic clk,
	input logic rst_n_reg,
	input logic agg_ready_i,
	input logic accu_finish_o,
	input logic agg_valid_o
);

	// count of failed assertions
	int fail_cnt = 0;

	// outputs quiet right after a reset edge
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n_reg |=> (!agg_valid_o && !accu_finish_o))
		else begin
			fail_cnt++;
			$error("agg_valid_o or accu_finish_o high after reset");
		end

	// finish flag and result words never overlap
	a_finish_no_word: assert property (@(posedge clk) disable iff (!rst_n_reg)
		!(agg_valid_o && accu_finish_o))
		else begin
			fail_cnt++;
			$error("agg_valid_o high while accu_finish_o is high");
		end

	// finish only drops once the aggregator is ready
	a_finish_needs_ready: assert property (@(posedge clk) disable iff (!rst_n_reg)
		$fell(accu_finish_o) |-> $past(agg_ready_i))
		else begin
			fail_cnt++;
			$error("accu_finish_o fell without agg_ready_i");
		end

endmodule

bind kmeans_accumulation kmeans_accumulation_assertions i_assertions (
	.clk(clk),
	.rst_n_reg(rst_n_reg),
	.agg_ready_i(agg_ready_i),
	.accu_finish_o(accu_finish_o),
	.agg_valid_o(agg_valid_o)
);

// ==== source/kmeans_accumulation.sv ====
`timescale 1ns/1ns

module kmeans_accumulation (
	input logic clk,
	input logic rst_n_reg,
	// one strobe per dimension
	input logic feature_valid_i,
	input logic [31:0] feature_i,
	// one strobe per sample
	input logic dist_valid_i,
	input logic [63:0] min_dist_i,
	input logic [3:0] cluster_i,
	input logic terminate_i,
	// runtime sizes, stable per iteration
	input logic [4:0] data_dim_i,
	input logic [3:0] num_cluster_i,
	// aggregator side
	input logic agg_ready_i,
	output logic accu_finish_o,
	output logic agg_valid_o,
	output logic [63:0] agg_data_o
);

	pair_if pair_bus ();
	agg_if agg_bus ();

	// decode
	sample_pairing i_sample_pairing (
		.clk(clk),
		.rst_n_reg(rst_n_reg),
		.feature_valid_i(feature_valid_i),
		.feature_i(feature_i),
		.dist_valid_i(dist_valid_i),
		.cluster_i(cluster_i),
		.data_dim_i(data_dim_i),
		.pair(pair_bus.source)
	);

	// execute
	centroid_accumulator i_centroid_accumulator (
		.clk(clk),
		.rst_n_reg(rst_n_reg),
		.pair(pair_bus.sink),
		.agg(agg_bus.target),
		.dist_valid_i(dist_valid_i),
		.min_dist_i(min_dist_i)
	);

	// result
	result_sequencer i_result_sequencer (
		.clk(clk),
		.rst_n_reg(rst_n_reg),
		.terminate_i(terminate_i),
		.agg_ready_i(agg_ready_i),
		.data_dim_i(data_dim_i),
		.num_cluster_i(num_cluster_i),
		.pair(pair_bus.monitor),
		.agg(agg_bus.master),
		.accu_finish_o(accu_finish_o),
		.agg_valid_o(agg_valid_o),
		.agg_data_o(agg_data_o)
	);

endmodule

// ==== source/result_sequencer.sv ====
`timescale 1ns/1ns

module result_sequencer (
	input logic clk,
	input logic rst_n_reg,
	input logic terminate_i,
	input logic agg_ready_i,
	input kmeans_cfg_pkg::dim_t data_dim_i,
	input kmeans_cfg_pkg::cluster_t num_cluster_i,
	pair_if.monitor pair,
	agg_if.master agg,
	output logic accu_finish_o,
	output logic agg_valid_o,
	output kmeans_agg_pkg::acc_word_t agg_data_o
);
	import kmeans_cfg_pkg::*;
	import kmeans_agg_pkg::*;

	agg_state_t state;

	// walk clusters, then dimensions inside each cluster
	cluster_t clus_cnt;
	dim_t dim_cnt;
	logic last_clus;
	logic last_dim;

	// ram read issued last cycle, data on sum_data now
	logic sum_rd_q;

	assign last_clus = (clus_cnt == cluster_t'(num_cluster_i - 1'b1));
	assign last_dim = (dim_cnt == dim_t'(data_dim_i - 1'b1));

	//////////////////////////////////////////////////////////////////////
	// control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_reg) begin
			state <= IDLE;
			clus_cnt <= '0;
			dim_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (terminate_i) begin
						state <= DRAIN;
					end
				end
				// fifos empty and no write pending
				DRAIN: begin
					if (pair.drained && !agg.busy) begin
						state <= WAIT_READY;
					end
				end
				WAIT_READY: begin
					clus_cnt <= '0;
					if (agg_ready_i) begin
						state <= SEND_COUNT;
					end
				end
				// one count word per cluster
				SEND_COUNT: begin
					if (last_clus) begin
						clus_cnt <= '0;
						dim_cnt <= '0;
						state <= SEND_SUM;
					end else begin
						clus_cnt <= clus_cnt + 1'b1;
					end
				end
				// cluster-major sum reads
				SEND_SUM: begin
					if (last_dim) begin
						dim_cnt <= '0;
						if (last_clus) begin
							clus_cnt <= '0;
							state <= SEND_SSE;
						end else begin
							clus_cnt <= clus_cnt + 1'b1;
						end
					end else begin
						dim_cnt <= dim_cnt + 1'b1;
					end
				end
				// hold while the last sum leaves
				SEND_SSE: begin
					if (!sum_rd_q) begin
						state <= CLEAR;
					end
				end
				CLEAR: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign accu_finish_o = (state == WAIT_READY);
	assign agg.agg_active = (state == SEND_SUM);
	assign agg.rd_addr = {clus_cnt[MAX_CLUSTER_BITS-1:0], dim_cnt[MAX_DIM_BITS-1:0]};
	assign agg.count_sel = clus_cnt;
	// counts and sse zeroed for next iteration
	assign agg.clear = (state == CLEAR);

	//////////////////////////////////////////////////////////////////////
	// output words
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_reg) begin
			sum_rd_q <= 1'b0;
			agg_valid_o <= 1'b0;
		end else begin
			sum_rd_q <= (state == SEND_SUM);
			agg_valid_o <= sum_rd_q || (state == SEND_COUNT) ||
				(state == SEND_SSE && !sum_rd_q);
		end
	end

	// sum data has priority, it overlaps the first sse cycle
	always_ff @(posedge clk) begin
		if (sum_rd_q) begin
			agg_data_o <= agg.sum_data;
		end else if (state == SEND_COUNT) begin
			agg_data_o <= agg.count_data;
		end else begin
			agg_data_o <= agg.sse_data;
		end
	end

endmodule

// ==== source/centroid_accumulator.sv ====
`timescale 1ns/1ns

module centroid_accumulator (
	input logic clk,
	input logic rst_n_reg,
	pair_if.sink pair,
	agg_if.target agg,
	input logic dist_valid_i,
	input kmeans_agg_pkg::acc_word_t min_dist_i
);
	import kmeans_cfg_pkg::*;
	import kmeans_agg_pkg::*;

	// ram ports
	logic ram_we;
	ram_addr_t ram_waddr;
	ram_addr_t ram_raddr;
	acc_word_t ram_wdata;
	acc_word_t ram_rdata;
	ram_addr_t beat_addr;

	// read data returning
	logic rd_valid;
	ram_addr_t rd_addr_q;
	feature_t rd_feature_q;

	// sum registered, written this cycle
	logic wr_valid;
	ram_addr_t wr_addr_q;
	acc_word_t wr_sum_q;

	// zeroing behind aggregation reads
	logic clr_we;
	ram_addr_t clr_addr_q;

	// per-cluster sample counts and sse
	acc_word_t counts [2**MAX_CLUSTER_BITS];
	acc_word_t sse;
	logic dist_valid_q;
	acc_word_t min_dist_q;

	assign beat_addr = {pair.cluster[MAX_CLUSTER_BITS-1:0], pair.dim[MAX_DIM_BITS-1:0]};

	//////////////////////////////////////////////////////////////////////
	// read-modify-write pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_reg) begin
			rd_valid <= 1'b0;
			wr_valid <= 1'b0;
			clr_we <= 1'b0;
		end else begin
			rd_valid <= pair.beat_valid;
			wr_valid <= rd_valid;
			clr_we <= agg.agg_active;
		end
	end

	// zero-extend feature onto stored sum
	always_ff @(posedge clk) begin
		rd_addr_q <= beat_addr;
		rd_feature_q <= pair.feature;
		wr_addr_q <= rd_addr_q;
		wr_sum_q <= ram_rdata + {{(ACC_W-FEATURE_W){1'b0}}, rd_feature_q};
		clr_addr_q <= agg.rd_addr;
	end

	// sequencer owns the read port during aggregation
	assign ram_raddr = agg.agg_active ? agg.rd_addr : beat_addr;
	assign ram_we = wr_valid | clr_we;
	assign ram_waddr = clr_we ? clr_addr_q : wr_addr_q;
	assign ram_wdata = clr_we ? '0 : wr_sum_q;

	accu_ram i_accu_ram (
		.clk(clk),
		.we_i(ram_we),
		.waddr_i(ram_waddr),
		.wdata_i(ram_wdata),
		.raddr_i(ram_raddr),
		.rdata_o(ram_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// counts and sse
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_reg || agg.clear) begin
			counts <= '{default: '0};
			sse <= '0;
			dist_valid_q <= 1'b0;
		end else begin
			dist_valid_q <= dist_valid_i;
			// one count per finished sample
			if (pair.beat_valid && pair.last_dim) begin
				counts[pair.cluster[MAX_CLUSTER_BITS-1:0]] <=
					counts[pair.cluster[MAX_CLUSTER_BITS-1:0]] + 1'b1;
			end
			if (dist_valid_q) begin
				sse <= sse + min_dist_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		min_dist_q <= min_dist_i;
	end

	// anything still headed for ram or sse
	assign agg.busy = pair.beat_valid | rd_valid | wr_valid | dist_valid_q;
	assign agg.sum_data = ram_rdata;
	assign agg.count_data = counts[agg.count_sel[MAX_CLUSTER_BITS-1:0]];
	assign agg.sse_data = sse;

endmodule

// ==== source/sample_pairing.sv ====
`timescale 1ns/1ns

module sample_pairing (
	input logic clk,
	input logic rst_n_reg,
	input logic feature_valid_i,
	input kmeans_cfg_pkg::feature_t feature_i,
	input logic dist_valid_i,
	input kmeans_cfg_pkg::cluster_t cluster_i,
	input kmeans_cfg_pkg::dim_t data_dim_i,
	pair_if.source pair
);
	import kmeans_cfg_pkg::*;

	// feature buffer
	feature_t feat_head;
	logic feat_valid;
	logic feat_empty;

	// cluster record buffer, one entry per sample
	cluster_t clus_head;
	logic clus_valid;
	logic clus_empty;

	// position inside the current sample
	dim_t dim_cnt;
	logic fire;
	logic last;

	//////////////////////////////////////////////////////////////////////
	// input buffers
	//////////////////////////////////////////////////////////////////////

	sync_fifo #(.WIDTH(FEATURE_W), .DEPTH_BITS(FIFO_DEPTH_BITS)) i_feature_fifo (
		.clk(clk),
		.rst_n_reg(rst_n_reg),
		.wr_en_i(feature_valid_i),
		.wr_data_i(feature_i),
		.rd_en_i(fire),
		.rd_data_o(feat_head),
		.valid_o(feat_valid),
		.empty_o(feat_empty),
		.full_o()
	);

	sync_fifo #(.WIDTH($bits(cluster_t)), .DEPTH_BITS(FIFO_DEPTH_BITS)) i_cluster_fifo (
		.clk(clk),
		.rst_n_reg(rst_n_reg),
		.wr_en_i(dist_valid_i),
		.wr_data_i(cluster_i),
		.rd_en_i(fire & last),
		.rd_data_o(clus_head),
		.valid_o(clus_valid),
		.empty_o(clus_empty),
		.full_o()
	);

	//////////////////////////////////////////////////////////////////////
	// pairing
	//////////////////////////////////////////////////////////////////////

	// both heads present, take one feature
	assign fire = feat_valid & clus_valid;
	assign last = (dim_cnt == dim_t'(data_dim_i - 1'b1));
	assign pair.drained = feat_empty & clus_empty;

	// walk dimensions, wrap at end of sample
	always_ff @(posedge clk) begin
		if (!rst_n_reg) begin
			dim_cnt <= '0;
			pair.beat_valid <= 1'b0;
		end else begin
			pair.beat_valid <= fire;
			if (fire) begin
				dim_cnt <= last ? '0 : dim_cnt + 1'b1;
			end
		end
	end

	// beat payload, leaves one cycle after both heads valid
	always_ff @(posedge clk) begin
		pair.feature <= feat_head;
		pair.cluster <= clus_head;
		pair.dim <= dim_cnt;
		pair.last_dim <= last;
	end

endmodule

// ==== source/accu_ram.sv ====
`timescale 1ns/1ns

module accu_ram (
	input logic clk,
	input logic we_i,
	input kmeans_cfg_pkg::ram_addr_t waddr_i,
	input kmeans_agg_pkg::acc_word_t wdata_i,
	input kmeans_cfg_pkg::ram_addr_t raddr_i,
	output kmeans_agg_pkg::acc_word_t rdata_o
);
	import kmeans_cfg_pkg::*;
	import kmeans_agg_pkg::*;

	// one word per cluster and dimension
	acc_word_t mem [2**(MAX_CLUSTER_BITS+MAX_DIM_BITS)];

	// block ram init, sums start at zero
	initial begin
		for (int i = 0; i < 2**(MAX_CLUSTER_BITS+MAX_DIM_BITS); i++) begin
			mem[i] = '0;
		end
	end

	// read-first, one cycle latency
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i];
	end

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = kmeans_cfg_pkg::FEATURE_W,
	parameter int DEPTH_BITS = kmeans_cfg_pkg::FIFO_DEPTH_BITS
) (
	input logic clk,
	input logic rst_n_reg,
	input logic wr_en_i,
	input logic [WIDTH-1:0] wr_data_i,
	input logic rd_en_i,
	output logic [WIDTH-1:0] rd_data_o,
	output logic valid_o,
	output logic empty_o,
	output logic full_o
);

	// entry storage
	logic [WIDTH-1:0] mem [2**DEPTH_BITS];

	// msb is the wrap bit
	logic [DEPTH_BITS:0] wr_ptr;
	logic [DEPTH_BITS:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	// same index on the same lap
	assign empty_o = (wr_ptr == rd_ptr);
	// same index with the writer one lap ahead
	assign full_o = (wr_ptr[DEPTH_BITS] != rd_ptr[DEPTH_BITS]) &&
		(wr_ptr[DEPTH_BITS-1:0] == rd_ptr[DEPTH_BITS-1:0]);

	// show-ahead head entry
	assign valid_o = ~empty_o;
	assign rd_data_o = mem[rd_ptr[DEPTH_BITS-1:0]];

	// writes into a full fifo are lost
	assign do_wr = wr_en_i & ~full_o;
	assign do_rd = rd_en_i & ~empty_o;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[DEPTH_BITS-1:0]] <= wr_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_reg) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

// ==== source/accu_ifs.sv ====
`timescale 1ns/1ns

// decode stage to execute and result stages
interface pair_if;
	import kmeans_cfg_pkg::*;

	logic beat_valid;
	feature_t feature;
	cluster_t cluster;
	dim_t dim;
	logic last_dim;
	// both input fifos empty
	logic drained;

	modport source (output beat_valid, feature, cluster, dim, last_dim, drained);
	modport sink (input beat_valid, feature, cluster, dim, last_dim);
	modport monitor (input drained);
endinterface

// result stage borrows the ram and reads the counters
interface agg_if;
	import kmeans_cfg_pkg::*;
	import kmeans_agg_pkg::*;

	logic agg_active;
	ram_addr_t rd_addr;
	cluster_t count_sel;
	logic clear;
	logic busy;
	acc_word_t sum_data;
	acc_word_t count_data;
	acc_word_t sse_data;

	modport master (output agg_active, rd_addr, count_sel, clear,
		input busy, sum_data, count_data, sse_data);
	modport target (input agg_active, rd_addr, count_sel, clear,
		output busy, sum_data, count_data, sse_data);
endinterface

// ==== source/kmeans_agg_pkg.sv ====
package kmeans_agg_pkg;

	//////////////////////////////////////////////////////////////////////
	// result words
	//////////////////////////////////////////////////////////////////////

	// accumulator and output word
	typedef logic [kmeans_cfg_pkg::ACC_W-1:0] acc_word_t;

	//////////////////////////////////////////////////////////////////////
	// result sequencer states
	//////////////////////////////////////////////////////////////////////

	// drain waits for empty fifos and idle rmw pipeline
	// send_sse also absorbs the last sum read in flight
	typedef enum logic [2:0] {
		IDLE,
		DRAIN,
		WAIT_READY,
		SEND_COUNT,
		SEND_SUM,
		SEND_SSE,
		CLEAR
	} agg_state_t;

endpackage

// ==== source/kmeans_cfg_pkg.sv ====
package kmeans_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// data widths
	//////////////////////////////////////////////////////////////////////

	// one feature word per dimension
	localparam int FEATURE_W = 32;
	// sums, counts and sse all share this width
	localparam int ACC_W = 64;

	//////////////////////////////////////////////////////////////////////
	// accumulator limits
	//////////////////////////////////////////////////////////////////////

	// up to 8 clusters
	localparam int MAX_CLUSTER_BITS = 3;
	// up to 16 dimensions
	localparam int MAX_DIM_BITS = 4;
	// below this the rmw pipeline would hit its own write
	localparam int MIN_DIM = 4;
	// 32 entries per input buffer
	localparam int FIFO_DEPTH_BITS = 5;

	// index or total, one extra bit so the total fits
	typedef logic [MAX_CLUSTER_BITS:0] cluster_t;
	typedef logic [MAX_DIM_BITS:0] dim_t;
	// cluster index in the upper bits, dimension below
	typedef logic [MAX_CLUSTER_BITS+MAX_DIM_BITS-1:0] ram_addr_t;
	typedef logic [FEATURE_W-1:0] feature_t;

endpackage
